// ==== hw/mem_pipe_pkg.sv ====
/*
 * Shared widths for the memory pipe
 * Load/store operation enum and access size enum
 */

`default_nettype none

package mem_pipe_pkg;

  // Data path and register width
  localparam int DATA_W = 64;

  // Effective address is cut down to the virtual width
  localparam int VADDR_W = 32;
  localparam int PADDR_W = 24;

  // 4 KiB pages
  localparam int PAGE_OFFSET_W = 12;

  localparam int VTAG_W = VADDR_W - PAGE_OFFSET_W;
  localparam int PTAG_W = PADDR_W - PAGE_OFFSET_W;

  localparam int REG_ADDR_W = 5;

  // Integer load and store operations
  typedef enum logic [3:0] {
    op_lb  = 4'h0,
    op_lbu = 4'h1,
    op_lh  = 4'h2,
    op_lhu = 4'h3,
    op_lw  = 4'h4,
    op_lwu = 4'h5,
    op_ld  = 4'h6,
    op_sb  = 4'h8,
    op_sh  = 4'h9,
    op_sw  = 4'ha,
    op_sd  = 4'hb
  } mem_op_e;

  // Access size in bytes is 1 << size
  typedef enum logic [1:0] {
    size_b = 2'b00,
    size_h = 2'b01,
    size_w = 2'b10,
    size_d = 2'b11
  } mem_size_e;

endpackage

`default_nettype wire

// ==== hw/mem_agen.sv ====
/*
 * Address generation for the memory pipe
 * Effective address, access size, load/store class, alignment check
 */

`timescale 1ns/1ps
`default_nettype none

module mem_agen (
  input  mem_pipe_pkg::mem_op_e                op_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]      rs1_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]      imm_i,
  output logic [mem_pipe_pkg::VADDR_W-1:0]     eaddr_o,
  output mem_pipe_pkg::mem_size_e              size_o,
  output logic                                 is_load_o,
  output logic                                 is_store_o,
  output logic                                 misaligned_o
);

  import mem_pipe_pkg::*;

  logic [DATA_W-1:0] sum;

  assign sum     = rs1_i + imm_i;
  assign eaddr_o = sum[VADDR_W-1:0];

  always_comb
  begin
    size_o     = size_d;
    is_load_o  = 1'b0;
    is_store_o = 1'b0;
    case (op_i)
      op_lb, op_lbu:  begin size_o = size_b; is_load_o = 1'b1; end
      op_lh, op_lhu:  begin size_o = size_h; is_load_o = 1'b1; end
      op_lw, op_lwu:  begin size_o = size_w; is_load_o = 1'b1; end
      op_ld:          begin size_o = size_d; is_load_o = 1'b1; end
      op_sb:          begin size_o = size_b; is_store_o = 1'b1; end
      op_sh:          begin size_o = size_h; is_store_o = 1'b1; end
      op_sw:          begin size_o = size_w; is_store_o = 1'b1; end
      op_sd:          begin size_o = size_d; is_store_o = 1'b1; end
      default:        size_o = size_d;
    endcase
  end

  // Natural alignment to the access size
  always_comb
  begin
    case (size_o)
      size_b:  misaligned_o = 1'b0;
      size_h:  misaligned_o = eaddr_o[0];
      size_w:  misaligned_o = |eaddr_o[1:0];
      default: misaligned_o = |eaddr_o[2:0];
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mem_dtlb.sv ====
/*
 * Fully associative data TLB
 * External fill with round-robin victim, sfence flush, registered lookup
 */

`timescale 1ns/1ps
`default_nettype none

module mem_dtlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              sfence_i,
  input  logic                              fill_v_i,
  input  logic [mem_pipe_pkg::VTAG_W-1:0]   fill_vtag_i,
  input  logic [mem_pipe_pkg::PTAG_W-1:0]   fill_ptag_i,
  input  logic                              fill_r_i,
  input  logic                              fill_w_i,
  input  logic                              lookup_v_i,
  input  logic [mem_pipe_pkg::VTAG_W-1:0]   vtag_i,
  output logic                              hit_o,
  output logic [mem_pipe_pkg::PTAG_W-1:0]   ptag_o,
  output logic                              perm_r_o,
  output logic                              perm_w_o
);

  import mem_pipe_pkg::*;

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_r;
  logic [VTAG_W-1:0]      vtag_r [TLB_ENTRIES];
  logic [PTAG_W-1:0]      ptag_r [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] perm_r_r;
  logic [TLB_ENTRIES-1:0] perm_w_r;
  logic [IDX_W-1:0]       victim_r;

  logic             fill_hit;
  logic [IDX_W-1:0] fill_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             lk_hit;
  logic [IDX_W-1:0] lk_idx;

  // Returns {hit, index} of the valid entry holding tag
  function automatic logic [IDX_W:0] find_entry(input logic [VTAG_W-1:0] tag);
    logic [IDX_W:0] res;
    res = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--)
    begin
      if (valid_r[i] && (vtag_r[i] == tag))
        res = {1'b1, IDX_W'(i)};
    end
    return res;
  endfunction

  always_comb
  begin
    {fill_hit, fill_idx} = find_entry(fill_vtag_i);
    {lk_hit, lk_idx}     = find_entry(vtag_i);
  end

  // Refill of an existing tag overwrites it in place
  assign wr_idx = fill_hit ? fill_idx : victim_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_r  <= '0;
      victim_r <= '0;
    end
    else if (sfence_i)
      valid_r <= '0;
    else if (fill_v_i)
    begin
      valid_r[wr_idx] <= 1'b1;
      if (!fill_hit)
        victim_r <= (victim_r == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
    begin
      vtag_r[wr_idx]   <= fill_vtag_i;
      ptag_r[wr_idx]   <= fill_ptag_i;
      perm_r_r[wr_idx] <= fill_r_i;
      perm_w_r[wr_idx] <= fill_w_i;
    end
  end

  // Lookup result lands in the early stage
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      hit_o <= 1'b0;
    else
      hit_o <= lookup_v_i & lk_hit;
  end

  always_ff @(posedge clk_i)
  begin
    ptag_o   <= ptag_r[lk_idx];
    perm_r_o <= perm_r_r[lk_idx];
    perm_w_o <= perm_w_r[lk_idx];
  end

endmodule

`default_nettype wire

// ==== hw/mem_stage_ctrl.sv ====
/*
 * Early and final stage control
 * Valid chains with flush kill, physical address, prioritized fault flags,
 * RAM access strobes for legal accesses
 */

`timescale 1ns/1ps
`default_nettype none

module mem_stage_ctrl #(
  parameter int RAM_WORDS = 256
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  flush_i,
  input  logic                                  trans_en_i,
  input  logic                                  valid_i,
  input  logic                                  is_load_i,
  input  logic                                  is_store_i,
  input  logic                                  misaligned_i,
  input  logic [mem_pipe_pkg::VADDR_W-1:0]      eaddr_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]   rd_addr_i,
  input  logic                                  tlb_hit_i,
  input  logic [mem_pipe_pkg::PTAG_W-1:0]       tlb_ptag_i,
  input  logic                                  tlb_perm_r_i,
  input  logic                                  tlb_perm_w_i,
  output logic                                  early_v_o,
  output logic                                  load_misaligned_o,
  output logic                                  store_misaligned_o,
  output logic                                  tlb_load_miss_o,
  output logic                                  tlb_store_miss_o,
  output logic                                  load_page_fault_o,
  output logic                                  store_page_fault_o,
  output logic                                  load_access_fault_o,
  output logic                                  store_access_fault_o,
  output logic                                  final_v_o,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]   final_rd_addr_o,
  output logic                                  ram_rd_o,
  output logic                                  ram_wr_o,
  output logic [mem_pipe_pkg::PADDR_W-1:0]      ram_paddr_o
);

  import mem_pipe_pkg::*;

  localparam logic [PADDR_W:0] RAM_BYTES = (PADDR_W + 1)'(RAM_WORDS * 8);

  logic                  ld_r, st_r, mis_r, trans_en_r;
  logic [PADDR_W-1:0]    eaddr_r;
  logic [REG_ADDR_W-1:0] rd_r;
  logic [PADDR_W-1:0]    paddr;
  logic                  miss, page_fault, access_fault;
  logic                  chk_miss, chk_pf, chk_af, legal;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      early_v_o <= 1'b0;
      final_v_o <= 1'b0;
    end
    else
    begin
      early_v_o <= valid_i & ~flush_i;
      final_v_o <= early_v_o & ~flush_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ld_r            <= is_load_i;
    st_r            <= is_store_i;
    mis_r           <= misaligned_i;
    trans_en_r      <= trans_en_i;
    eaddr_r         <= eaddr_i[PADDR_W-1:0];
    rd_r            <= rd_addr_i;
    final_rd_addr_o <= rd_r;
  end

  // Untranslated accesses use the low address bits directly
  assign paddr = trans_en_r ? {tlb_ptag_i, eaddr_r[PAGE_OFFSET_W-1:0]} : eaddr_r;

  assign miss         = trans_en_r & ~tlb_hit_i;
  assign page_fault   = trans_en_r & ((ld_r & ~tlb_perm_r_i) | (st_r & ~tlb_perm_w_i));
  assign access_fault = {1'b0, paddr} >= RAM_BYTES;

  // Each check only applies once all higher priority ones have passed
  assign chk_miss = early_v_o & ~mis_r;
  assign chk_pf   = chk_miss & ~miss;
  assign chk_af   = chk_pf & ~page_fault;
  assign legal    = chk_af & ~access_fault;

  assign load_misaligned_o    = early_v_o & ld_r & mis_r;
  assign store_misaligned_o   = early_v_o & st_r & mis_r;
  assign tlb_load_miss_o      = chk_miss & ld_r & miss;
  assign tlb_store_miss_o     = chk_miss & st_r & miss;
  assign load_page_fault_o    = chk_pf & ld_r & page_fault;
  assign store_page_fault_o   = chk_pf & st_r & page_fault;
  assign load_access_fault_o  = chk_af & ld_r & access_fault;
  assign store_access_fault_o = chk_af & st_r & access_fault;

  assign ram_rd_o    = legal & ld_r;
  assign ram_wr_o    = legal & st_r & ~flush_i;
  assign ram_paddr_o = paddr;

endmodule

`default_nettype wire

// ==== hw/mem_data_ram.sv ====
/*
 * Byte-lane data RAM of double words
 * Store merge by size and offset, registered read, load extract and extend
 */

`timescale 1ns/1ps
`default_nettype none

module mem_data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                                clk_i,
  input  logic                                rd_i,
  input  logic                                wr_i,
  input  logic [mem_pipe_pkg::PADDR_W-1:0]    paddr_i,
  input  mem_pipe_pkg::mem_size_e             size_i,
  input  mem_pipe_pkg::mem_op_e               op_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]     st_data_i,
  output logic [mem_pipe_pkg::DATA_W-1:0]     ld_data_o
);

  import mem_pipe_pkg::*;

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [DATA_W-1:0] mem [RAM_WORDS];

  logic [IDX_W-1:0]  idx;
  logic [2:0]        off;
  logic [7:0]        be_base;
  logic [7:0]        be;
  logic [DATA_W-1:0] wdata;

  logic [DATA_W-1:0] word_r;
  logic [2:0]        off_r;
  mem_op_e           op_r;
  logic              rd_r;
  logic [DATA_W-1:0] lane;
  logic [DATA_W-1:0] ext;

  assign idx = paddr_i[IDX_W+2:3];
  assign off = paddr_i[2:0];

  always_comb
  begin
    case (size_i)
      size_b:  be_base = 8'h01;
      size_h:  be_base = 8'h03;
      size_w:  be_base = 8'h0f;
      default: be_base = 8'hff;
    endcase
  end

  // Store data moves up to its byte lane
  assign be    = be_base << off;
  assign wdata = st_data_i << {off, 3'b000};

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < 8; i++)
    begin
      if (wr_i && be[i])
        mem[idx][8*i +: 8] <= wdata[8*i +: 8];
    end
  end

  always_ff @(posedge clk_i)
  begin
    word_r <= mem[idx];
    off_r  <= off;
    op_r   <= op_i;
    rd_r   <= rd_i;
  end

  assign lane = word_r >> {off_r, 3'b000};

  always_comb
  begin
    case (op_r)
      op_lb:   ext = {{(DATA_W-8){lane[7]}}, lane[7:0]};
      op_lbu:  ext = {{(DATA_W-8){1'b0}}, lane[7:0]};
      op_lh:   ext = {{(DATA_W-16){lane[15]}}, lane[15:0]};
      op_lhu:  ext = {{(DATA_W-16){1'b0}}, lane[15:0]};
      op_lw:   ext = {{(DATA_W-32){lane[31]}}, lane[31:0]};
      op_lwu:  ext = {{(DATA_W-32){1'b0}}, lane[31:0]};
      op_ld:   ext = lane;
      default: ext = '0;
    endcase
  end

  // Stores, faults and flushed loads return zero
  assign ld_data_o = rd_r ? ext : '0;

endmodule

`default_nettype wire

// ==== hw/mem_pipe.sv ====
/*
 * Memory pipe top level
 * Address generation, data TLB, stage control and data RAM
 */

`timescale 1ns/1ps
`default_nettype none

module mem_pipe #(
  parameter int TLB_ENTRIES = 4,
  parameter int RAM_WORDS   = 256
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  valid_i,
  input  mem_pipe_pkg::mem_op_e                 op_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]       rs1_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]       rs2_i,
  input  logic [mem_pipe_pkg::DATA_W-1:0]       imm_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]   rd_addr_i,
  input  logic                                  trans_en_i,
  input  logic                                  flush_i,
  input  logic                                  sfence_i,
  input  logic                                  tlb_fill_v_i,
  input  logic [mem_pipe_pkg::VTAG_W-1:0]       tlb_fill_vtag_i,
  input  logic [mem_pipe_pkg::PTAG_W-1:0]       tlb_fill_ptag_i,
  input  logic                                  tlb_fill_r_i,
  input  logic                                  tlb_fill_w_i,
  output logic                                  incr_v_o,
  output logic [mem_pipe_pkg::VADDR_W-1:0]      incr_data_o,
  output logic                                  early_v_o,
  output logic                                  load_misaligned_o,
  output logic                                  store_misaligned_o,
  output logic                                  tlb_load_miss_o,
  output logic                                  tlb_store_miss_o,
  output logic                                  load_page_fault_o,
  output logic                                  store_page_fault_o,
  output logic                                  load_access_fault_o,
  output logic                                  store_access_fault_o,
  output logic                                  final_v_o,
  output logic [mem_pipe_pkg::DATA_W-1:0]       final_data_o,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]   final_rd_addr_o
);

  import mem_pipe_pkg::*;

  logic [VADDR_W-1:0] eaddr;
  mem_size_e          size;
  logic               is_load, is_store, misaligned;
  logic               lookup_v;

  logic               tlb_hit, tlb_perm_r, tlb_perm_w;
  logic [PTAG_W-1:0]  tlb_ptag;

  logic               ram_rd, ram_wr;
  logic [PADDR_W-1:0] ram_paddr;

  mem_op_e            op_r;
  mem_size_e          size_r;
  logic [DATA_W-1:0]  rs2_r;

  mem_agen agen (
    .op_i(op_i), .rs1_i(rs1_i), .imm_i(imm_i),
    .eaddr_o(eaddr), .size_o(size),
    .is_load_o(is_load), .is_store_o(is_store), .misaligned_o(misaligned)
  );

  assign lookup_v = valid_i & trans_en_i & (is_load | is_store);

  mem_dtlb #(.TLB_ENTRIES(TLB_ENTRIES)) dtlb (
    .clk_i(clk_i), .rst_i(rst_i), .sfence_i(sfence_i),
    .fill_v_i(tlb_fill_v_i), .fill_vtag_i(tlb_fill_vtag_i),
    .fill_ptag_i(tlb_fill_ptag_i), .fill_r_i(tlb_fill_r_i), .fill_w_i(tlb_fill_w_i),
    .lookup_v_i(lookup_v), .vtag_i(eaddr[VADDR_W-1:PAGE_OFFSET_W]),
    .hit_o(tlb_hit), .ptag_o(tlb_ptag), .perm_r_o(tlb_perm_r), .perm_w_o(tlb_perm_w)
  );

  mem_stage_ctrl #(.RAM_WORDS(RAM_WORDS)) stage_ctrl (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i), .trans_en_i(trans_en_i),
    .valid_i(valid_i), .is_load_i(is_load), .is_store_i(is_store),
    .misaligned_i(misaligned), .eaddr_i(eaddr), .rd_addr_i(rd_addr_i),
    .tlb_hit_i(tlb_hit), .tlb_ptag_i(tlb_ptag),
    .tlb_perm_r_i(tlb_perm_r), .tlb_perm_w_i(tlb_perm_w),
    .early_v_o(early_v_o),
    .load_misaligned_o(load_misaligned_o), .store_misaligned_o(store_misaligned_o),
    .tlb_load_miss_o(tlb_load_miss_o), .tlb_store_miss_o(tlb_store_miss_o),
    .load_page_fault_o(load_page_fault_o), .store_page_fault_o(store_page_fault_o),
    .load_access_fault_o(load_access_fault_o),
    .store_access_fault_o(store_access_fault_o),
    .final_v_o(final_v_o), .final_rd_addr_o(final_rd_addr_o),
    .ram_rd_o(ram_rd), .ram_wr_o(ram_wr), .ram_paddr_o(ram_paddr)
  );

  // Operation and store data follow the op into the early stage
  always_ff @(posedge clk_i)
  begin
    op_r   <= op_i;
    size_r <= size;
    rs2_r  <= rs2_i;
  end

  mem_data_ram #(.RAM_WORDS(RAM_WORDS)) data_ram (
    .clk_i(clk_i), .rd_i(ram_rd), .wr_i(ram_wr), .paddr_i(ram_paddr),
    .size_i(size_r), .op_i(op_r), .st_data_i(rs2_r), .ld_data_o(final_data_o)
  );

  assign incr_v_o    = valid_i;
  assign incr_data_o = eaddr;

endmodule

`default_nettype wire

// ==== verification/mem_pipe_sva.sv ====
/*
 * Concurrent checks on the memory pipe
 * Stage valid timing, flush kill and fault flag exclusivity
 */

`timescale 1ns/1ps
`default_nettype none

module mem_pipe_sva_checks (
  input logic       clk_i,
  input logic       rst_i,
  input logic       valid_i,
  input logic       flush_i,
  input logic       early_v_i,
  input logic       final_v_i,
  input logic [7:0] flags_i
);

  // Early stage is exactly one cycle behind issue
  a_early_follows: assert property (@(posedge clk_i)
    (!rst_i && valid_i && !flush_i) |=> early_v_i)
    else $error("early_v_o did not follow valid_i");

  a_early_killed: assert property (@(posedge clk_i)
    (!rst_i && !(valid_i && !flush_i)) |=> !early_v_i)
    else $error("early_v_o high without an accepted operation");

  a_final_follows: assert property (@(posedge clk_i)
    (!rst_i && early_v_i && !flush_i) |=> final_v_i)
    else $error("final_v_o did not follow early_v_o");

  a_final_killed: assert property (@(posedge clk_i)
    (!rst_i && !(early_v_i && !flush_i)) |=> !final_v_i)
    else $error("final_v_o high without an operation in the early stage");

  a_one_flag: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(flags_i))
    else $error("more than one fault flag is high");

endmodule

bind mem_pipe mem_pipe_sva_checks sva (
  .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .flush_i(flush_i),
  .early_v_i(early_v_o), .final_v_i(final_v_o),
  .flags_i({load_misaligned_o, store_misaligned_o, tlb_load_miss_o, tlb_store_miss_o,
            load_page_fault_o, store_page_fault_o, load_access_fault_o, store_access_fault_o})
);

`default_nettype wire

// ==== verification/tb_mem_pipe.sv ====
/*
 * Testbench for the memory pipe
 * Clock and reset, TLB fill, random stimulus, reference model and checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_pipe;

  import mem_pipe_pkg::*;

  localparam int TLB_ENTRIES = 4;
  localparam int RAM_WORDS   = 256;
  localparam int RAM_BYTES   = RAM_WORDS * 8;
  localparam int BA_W        = $clog2(RAM_BYTES);

  // life is 2 for a normal op, 1 when flushed in early, 0 when flushed at issue
  typedef struct packed {
    int                    cyc;
    int                    life;
    logic [VADDR_W-1:0]    eaddr;
    logic [7:0]            flags;
    logic [DATA_W-1:0]     data;
    logic [REG_ADDR_W-1:0] rd;
  } exp_t;

  logic                  clk_i, rst_i, valid_i, trans_en_i, flush_i, sfence_i;
  mem_op_e               op_i;
  logic [DATA_W-1:0]     rs1_i, rs2_i, imm_i;
  logic [REG_ADDR_W-1:0] rd_addr_i;
  logic                  tlb_fill_v_i, tlb_fill_r_i, tlb_fill_w_i;
  logic [VTAG_W-1:0]     tlb_fill_vtag_i;
  logic [PTAG_W-1:0]     tlb_fill_ptag_i;
  wire                   incr_v_o, early_v_o, final_v_o;
  wire [VADDR_W-1:0]     incr_data_o;
  wire [7:0]             flags_o;
  wire [DATA_W-1:0]      final_data_o;
  wire [REG_ADDR_W-1:0]  final_rd_addr_o;

  // Reference byte memory and TLB copy
  logic [7:0]        mem_b [RAM_BYTES];
  logic              m_valid [TLB_ENTRIES];
  logic [VTAG_W-1:0] m_vtag [TLB_ENTRIES];
  logic [PTAG_W-1:0] m_ptag [TLB_ENTRIES];
  logic              m_r [TLB_ENTRIES];
  logic              m_w [TLB_ENTRIES];
  int                m_victim;

  integer seed;
  int     ncyc;
  exp_t   incr_q[$];
  exp_t   early_q[$];
  exp_t   final_q[$];
  exp_t   chk;

  mem_pipe #(.TLB_ENTRIES(TLB_ENTRIES), .RAM_WORDS(RAM_WORDS)) uut (
    .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i), .rs1_i(rs1_i),
    .rs2_i(rs2_i), .imm_i(imm_i), .rd_addr_i(rd_addr_i), .trans_en_i(trans_en_i),
    .flush_i(flush_i), .sfence_i(sfence_i), .tlb_fill_v_i(tlb_fill_v_i),
    .tlb_fill_vtag_i(tlb_fill_vtag_i), .tlb_fill_ptag_i(tlb_fill_ptag_i),
    .tlb_fill_r_i(tlb_fill_r_i), .tlb_fill_w_i(tlb_fill_w_i),
    .incr_v_o(incr_v_o), .incr_data_o(incr_data_o), .early_v_o(early_v_o),
    .load_misaligned_o(flags_o[7]), .store_misaligned_o(flags_o[6]),
    .tlb_load_miss_o(flags_o[5]), .tlb_store_miss_o(flags_o[4]),
    .load_page_fault_o(flags_o[3]), .store_page_fault_o(flags_o[2]),
    .load_access_fault_o(flags_o[1]), .store_access_fault_o(flags_o[0]),
    .final_v_o(final_v_o), .final_data_o(final_data_o), .final_rd_addr_o(final_rd_addr_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int size_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  // kind 1 picks a load, kind 2 a store, anything else any op
  function automatic mem_op_e pick_op(input int kind);
    logic [31:0] r;
    int          idx;
    r = rand32();
    if (kind == 1)
      idx = int'(r % 7);
    else if (kind == 2)
      idx = 7 + int'(r % 4);
    else
      idx = int'(r % 11);
    case (idx)
      0:       return op_lb;
      1:       return op_lbu;
      2:       return op_lh;
      3:       return op_lhu;
      4:       return op_lw;
      5:       return op_lwu;
      6:       return op_ld;
      7:       return op_sb;
      8:       return op_sh;
      9:       return op_sw;
      default: return op_sd;
    endcase
  endfunction

  function automatic logic [VADDR_W-1:0] aligned_addr(input mem_op_e op);
    logic [31:0] r;
    r = rand32() % 32'(RAM_BYTES);
    return r & ~32'(size_bytes(op) - 1);
  endfunction

  // Page offset that is aligned three times out of four
  function automatic logic [VADDR_W-1:0] paged_addr(input mem_op_e op, input int vt);
    logic [31:0] r;
    logic [PAGE_OFFSET_W-1:0] off;
    r = rand32();
    off = r[PAGE_OFFSET_W-1:0];
    if (r[31:30] != 2'b00)
      off = off & ~PAGE_OFFSET_W'(size_bytes(op) - 1);
    return {VTAG_W'(vt), off};
  endfunction

  function automatic void ref_access(input mem_op_e op, input logic [VADDR_W-1:0] ea,
                                     input logic trans, input logic [DATA_W-1:0] st,
                                     output logic [7:0] flg, output logic [DATA_W-1:0] data);
    int                 nb;
    int                 kind;
    logic               ld, hit, pr, pw;
    logic [PADDR_W-1:0] pa;
    logic [BA_W-1:0]    bi;
    logic [DATA_W-1:0]  raw;
    nb = size_bytes(op);
    ld = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    hit = 1'b0;
    pr = 1'b0;
    pw = 1'b0;
    pa = ea[PADDR_W-1:0];
    flg = '0;
    data = '0;
    raw = '0;
    if (trans)
    begin
      for (int i = 0; i < TLB_ENTRIES; i++)
      begin
        if (m_valid[i] && m_vtag[i] == ea[VADDR_W-1:PAGE_OFFSET_W])
        begin
          hit = 1'b1;
          pa = {m_ptag[i], ea[PAGE_OFFSET_W-1:0]};
          pr = m_r[i];
          pw = m_w[i];
        end
      end
    end
    if ((ea & 32'(nb - 1)) != 0)
      kind = 0;
    else if (trans && !hit)
      kind = 1;
    else if (trans && (ld ? !pr : !pw))
      kind = 2;
    else if ({8'b0, pa} >= 32'(RAM_BYTES))
      kind = 3;
    else
      kind = 4;
    if (kind < 4)
      flg[7 - 2*kind - (ld ? 0 : 1)] = 1'b1;
    else
    begin
      for (int b = 0; b < nb; b++)
      begin
        bi = pa[BA_W-1:0] + BA_W'(b);
        if (ld)
          raw[8*b +: 8] = mem_b[bi];
        else
          mem_b[bi] = st[8*b +: 8];
      end
      case (op)
        op_lb:   data = {{56{raw[7]}}, raw[7:0]};
        op_lh:   data = {{48{raw[15]}}, raw[15:0]};
        op_lw:   data = {{32{raw[31]}}, raw[31:0]};
        default: data = raw;
      endcase
    end
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic issue_op(input mem_op_e op, input logic [VADDR_W-1:0] ea, input logic trans,
                          input int life, input logic flush);
    exp_t              e;
    logic [7:0]        flg;
    logic [DATA_W-1:0] dat, rs1, st;
    logic [31:0]       r;
    rs1 = {rand32(), rand32()};
    st = {rand32(), rand32()};
    r = rand32();
    flg = '0;
    dat = '0;
    @(posedge clk_i);
    if (life == 2)
      ref_access(op, ea, trans, st, flg, dat);
    e.cyc = ncyc + 1;
    e.life = life;
    e.eaddr = ea;
    e.flags = flg;
    e.data = dat;
    e.rd = r[REG_ADDR_W-1:0];
    incr_q.push_back(e);
    valid_i <= 1'b1;
    op_i <= op;
    rs1_i <= rs1;
    imm_i <= {{(DATA_W-VADDR_W){1'b0}}, ea} - rs1;
    rs2_i <= st;
    rd_addr_i <= r[REG_ADDR_W-1:0];
    trans_en_i <= trans;
    flush_i <= flush;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    valid_i <= 1'b0;
    flush_i <= 1'b0;
  endtask

  task automatic drain_pipe();
    int waited;
    idle_cycle();
    waited = 0;
    while (incr_q.size() + early_q.size() + final_q.size() != 0)
    begin
      @(posedge clk_i);
      waited++;
      if (waited > 20)
        report_problem("Timeout: the pipe did not deliver every issued operation");
    end
  endtask

  task automatic fill_tlb(input int vt, input int pt, input logic r, input logic w);
    int idx;
    idx = -1;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (m_valid[i] && m_vtag[i] == VTAG_W'(vt) && idx < 0)
        idx = i;
    end
    if (idx < 0)
    begin
      idx = m_victim;
      m_victim = (m_victim + 1) % TLB_ENTRIES;
    end
    m_valid[idx] = 1'b1;
    m_vtag[idx] = VTAG_W'(vt);
    m_ptag[idx] = PTAG_W'(pt);
    m_r[idx] = r;
    m_w[idx] = w;
    @(posedge clk_i);
    tlb_fill_v_i <= 1'b1;
    tlb_fill_vtag_i <= VTAG_W'(vt);
    tlb_fill_ptag_i <= PTAG_W'(pt);
    tlb_fill_r_i <= r;
    tlb_fill_w_i <= w;
    @(posedge clk_i);
    tlb_fill_v_i <= 1'b0;
  endtask

  task automatic fence_tlb();
    for (int i = 0; i < TLB_ENTRIES; i++)
      m_valid[i] = 1'b0;
    @(posedge clk_i);
    sfence_i <= 1'b1;
    @(posedge clk_i);
    sfence_i <= 1'b0;
  endtask

  // Outputs are sampled at the falling edge with older stages first
  always @(negedge clk_i)
  begin
    ncyc = ncyc + 1;
    if (!rst_i)
    begin
      if (final_v_o)
      begin
        assert (final_q.size() > 0)
          else report_problem("final_v_o went high with no operation in flight");
        chk = final_q.pop_front();
        assert (ncyc == chk.cyc + 2)
          else report_mismatch($sformatf("final in cycle %0d for issue %0d", ncyc, chk.cyc));
        assert (final_data_o === chk.data && final_rd_addr_o === chk.rd)
          else report_mismatch($sformatf("final data %h rd %0d, expected %h rd %0d",
                                         final_data_o, final_rd_addr_o, chk.data, chk.rd));
      end
      if (early_v_o)
      begin
        assert (early_q.size() > 0)
          else report_problem("early_v_o went high with no operation in flight");
        chk = early_q.pop_front();
        assert (ncyc == chk.cyc + 1)
          else report_mismatch($sformatf("early in cycle %0d for issue %0d", ncyc, chk.cyc));
        assert (flags_o === chk.flags)
          else report_mismatch($sformatf("flags %b, expected %b at address %h",
                                         flags_o, chk.flags, chk.eaddr));
        if (chk.life == 2)
          final_q.push_back(chk);
      end
      else
        assert (flags_o == 8'h00)
          else report_mismatch($sformatf("flags %b without early_v_o", flags_o));
      if (incr_v_o)
      begin
        assert (incr_q.size() > 0)
          else report_problem("incr_v_o went high with no operation issued");
        chk = incr_q.pop_front();
        assert (incr_data_o === chk.eaddr)
          else report_mismatch($sformatf("incr_data_o %h, expected %h", incr_data_o, chk.eaddr));
        if (chk.life >= 1)
          early_q.push_back(chk);
      end
    end
  end

  initial
  begin
    mem_op_e            op;
    logic [VADDR_W-1:0] ea;
    logic [VADDR_W-1:0] bases [8];
    mem_op_e            mis_ops [8];
    logic [31:0]        r;
    seed = 32'hbad3_a66d;
    ncyc = 0;
    m_victim = 0;
    for (int i = 0; i < TLB_ENTRIES; i++)
      m_valid[i] = 1'b0;
    clk_i = 1'b0;
    rst_i = 1'b1;
    valid_i = 1'b0;
    op_i = op_lb;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    rd_addr_i = '0;
    trans_en_i = 1'b0;
    flush_i = 1'b0;
    sfence_i = 1'b0;
    tlb_fill_v_i = 1'b0;
    tlb_fill_vtag_i = '0;
    tlb_fill_ptag_i = '0;
    tlb_fill_r_i = 1'b0;
    tlb_fill_w_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // Untranslated stores fill the whole RAM before mixed stores and loads of every width
    for (int w = 0; w < RAM_WORDS; w++)
      issue_op(op_sd, 32'(w * 8), 1'b0, 2, 1'b0);
    for (int i = 0; i < 40; i++)
    begin
      op = pick_op(2);
      issue_op(op, aligned_addr(op), 1'b0, 2, 1'b0);
    end
    for (int i = 0; i < 70; i++)
    begin
      op = mem_op_e'(4'(i % 7));
      issue_op(op, aligned_addr(op), 1'b0, 2, 1'b0);
    end
    drain_pipe();

    // Misaligned accesses followed by a read back of the touched double words
    mis_ops = '{op_lh, op_lhu, op_lw, op_lwu, op_ld, op_sh, op_sw, op_sd};
    for (int i = 0; i < 8; i++)
    begin
      bases[i] = aligned_addr(op_ld);
      r = rand32();
      ea = bases[i] + 32'(1 + r % 7);
      if ((ea & 32'(size_bytes(mis_ops[i]) - 1)) == 0)
        ea = ea + 1;
      issue_op(mis_ops[i], ea, 1'b0, 2, 1'b0);
    end
    for (int i = 0; i < 8; i++)
      issue_op(op_ld, bases[i], 1'b0, 2, 1'b0);
    drain_pipe();

    // Translated accesses to full, read-only, write-only and out-of-RAM pages
    fill_tlb(1, 0, 1'b1, 1'b1);
    fill_tlb(2, 0, 1'b1, 1'b0);
    fill_tlb(3, 0, 1'b0, 1'b1);
    fill_tlb(4, 5, 1'b1, 1'b1);
    issue_op(op_ld, {20'd7, 12'h000}, 1'b1, 2, 1'b0);
    issue_op(op_sd, {20'd2, 12'h010}, 1'b1, 2, 1'b0);
    issue_op(op_lw, {20'd3, 12'h020}, 1'b1, 2, 1'b0);
    issue_op(op_ld, {20'd4, 12'h000}, 1'b1, 2, 1'b0);
    issue_op(op_sw, {20'd1, 12'h800}, 1'b1, 2, 1'b0);
    issue_op(op_lh, {20'd1, 12'h010}, 1'b1, 2, 1'b0);
    for (int i = 0; i < 60; i++)
    begin
      op = pick_op(0);
      r = rand32();
      issue_op(op, paged_addr(op, (r % 5 == 0) ? 7 : int'(1 + r % 4)), 1'b1, 2, 1'b0);
    end
    drain_pipe();

    // Fence drops the mapping until it is filled again
    fence_tlb();
    issue_op(op_ld, {20'd1, 12'h000}, 1'b1, 2, 1'b0);
    drain_pipe();
    fill_tlb(1, 0, 1'b1, 1'b1);
    issue_op(op_ld, {20'd1, 12'h008}, 1'b1, 2, 1'b0);
    drain_pipe();

    // One store is killed in the early stage and the next one at issue
    ea = aligned_addr(op_ld);
    issue_op(op_sd, ea, 1'b0, 1, 1'b0);
    issue_op(op_sd, ea, 1'b0, 0, 1'b1);
    idle_cycle();
    issue_op(op_ld, ea, 1'b0, 2, 1'b0);
    drain_pipe();

    // Back-to-back random traffic
    for (int i = 0; i < 200; i++)
    begin
      op = pick_op(0);
      r = rand32();
      issue_op(op, paged_addr(op, int'(r % 5)), r[31], 2, 1'b0);
    end
    drain_pipe();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/mem_pipe_pkg.sv
hw/mem_agen.sv
hw/mem_dtlb.sv
hw/mem_stage_ctrl.sv
hw/mem_data_ram.sv
hw/mem_pipe.sv
verification/mem_pipe_sva.sv
verification/tb_mem_pipe.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_mem_pipe \
  --Mdir obj_dir -o tb_mem_pipe
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mem_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi

exit 0
